/* hdl/cache_pkg.sv */
package cache_pkg;

  // ----------------------------------------------------------------------
  // geometry
  // ----------------------------------------------------------------------
  // tree replacement logic is built for exactly four ways
  localparam int num_way = 4;

  typedef logic [1:0] way_t;

  // ----------------------------------------------------------------------
  // encodings
  // ----------------------------------------------------------------------
  typedef enum logic [2:0] {
    invalid   = 3'd0,
    shared    = 3'd1,
    exclusive = 3'd2,
    modified  = 3'd3,
    migrated  = 3'd4
  } blk_st_e;

  typedef enum logic [1:0] {
    cdreq_rd  = 2'd0,
    cdreq_rfo = 2'd1,
    cdreq_wb  = 2'd2
  } cdreq_op_e;

  typedef enum logic [1:0] {
    sdreq_rd  = 2'd0,
    sdreq_rfo = 2'd1,
    sdreq_inv = 2'd2
  } sdreq_op_e;

  // snoop means another cache holds the block
  // fetch means it came from memory
  typedef enum logic {
    sursp_snoop = 1'b0,
    sursp_fetch = 1'b1
  } sursp_e;

  typedef enum logic [2:0] {
    idle       = 3'd0,
    allocate   = 3'd1,
    send_sdreq = 3'd2,
    wait_sursp = 3'd3,
    fill       = 3'd4,
    send_rsp   = 3'd5
  } req_fsm_e;

  // lookup result for the buffered request
  typedef struct packed {
    logic    hit;
    blk_st_e blk_st;
  } lookup_t;

endpackage

/* hdl/plru_repl.sv */
`timescale 1ns/1ps

module plru_repl #(
  parameter  int num_set   = 16,
  localparam int idx_width = $clog2(num_set)
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [idx_width-1:0] set_idx,
  input  logic                 touch,
  input  cache_pkg::way_t      way,
  output cache_pkg::way_t      victim
);

  // three tree bits per set
  // bit 2 picks the half, bit 1 splits ways 0/1 and bit 0 ways 2/3
  logic [2:0] tree [num_set];
  logic [2:0] cur;

  assign cur = tree[set_idx];

  // victim walks away from the recently used side
  assign victim[1] = cur[2];
  assign victim[0] = cur[2] ? cur[0] : cur[1];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < num_set; s++) begin
        tree[s] <= 3'b000;
      end
    end else if (touch) begin
      case (way)
        2'd0: begin
          tree[set_idx][2] <= 1'b1;
          tree[set_idx][1] <= 1'b1;
        end
        2'd1: begin
          tree[set_idx][2] <= 1'b1;
          tree[set_idx][1] <= 1'b0;
        end
        2'd2: begin
          tree[set_idx][2] <= 1'b0;
          tree[set_idx][0] <= 1'b1;
        end
        default: begin
          tree[set_idx][2] <= 1'b0;
          tree[set_idx][0] <= 1'b0;
        end
      endcase
    end
  end

endmodule

/* hdl/cache_req_fsm.sv */
`timescale 1ns/1ps

module cache_req_fsm (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 cdreq_valid,
  input  cache_pkg::lookup_t   lookup,
  input  cache_pkg::cdreq_op_e req_op,
  input  logic                 sdreq_ready,
  input  logic                 sursp_valid,
  input  logic                 cursp_ready,
  output logic                 capture,
  output logic                 commit,
  output logic                 fill,
  output logic                 cdreq_ready,
  output logic                 sdreq_valid,
  output cache_pkg::sdreq_op_e sdreq_op,
  output logic                 sursp_ready,
  output logic                 cursp_valid
);

  cache_pkg::req_fsm_e state;
  cache_pkg::req_fsm_e state_nxt;
  logic                need_down;

  // ----------------------------------------------------------------------
  // downstream decision
  // ----------------------------------------------------------------------
  // buffer and arrays stay untouched until commit, so the op holds steady
  // through send_sdreq
  always_comb begin
    need_down = 1'b0;
    sdreq_op  = cache_pkg::sdreq_rd;
    if (!lookup.hit) begin
      need_down = 1'b1;
      if (req_op == cache_pkg::cdreq_rd) begin
        sdreq_op = cache_pkg::sdreq_rd;
      end else begin
        sdreq_op = cache_pkg::sdreq_rfo;
      end
    end else if ((req_op != cache_pkg::cdreq_rd) &&
                 (lookup.blk_st == cache_pkg::shared)) begin
      // other holders drop their shared copies before a write
      need_down = 1'b1;
      sdreq_op  = cache_pkg::sdreq_inv;
    end
  end

  // ----------------------------------------------------------------------
  // state machine
  // ----------------------------------------------------------------------
  always_comb begin
    state_nxt = state;
    case (state)
      cache_pkg::idle: begin
        if (cdreq_valid) begin
          state_nxt = cache_pkg::allocate;
        end
      end
      cache_pkg::allocate: begin
        state_nxt = need_down ? cache_pkg::send_sdreq : cache_pkg::send_rsp;
      end
      cache_pkg::send_sdreq: begin
        if (sdreq_ready) begin
          state_nxt = cache_pkg::wait_sursp;
        end
      end
      cache_pkg::wait_sursp: begin
        if (sursp_valid) begin
          state_nxt = cache_pkg::fill;
        end
      end
      cache_pkg::fill: begin
        state_nxt = cache_pkg::send_rsp;
      end
      cache_pkg::send_rsp: begin
        if (cursp_ready) begin
          state_nxt = cache_pkg::idle;
        end
      end
      default: state_nxt = cache_pkg::idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= cache_pkg::idle;
    end else begin
      state <= state_nxt;
    end
  end

  // channel strobes and store controls
  assign capture     = (state == cache_pkg::idle) && cdreq_valid;
  assign cdreq_ready = (state == cache_pkg::allocate);
  assign commit      = ((state == cache_pkg::allocate) && !need_down) ||
                       (state == cache_pkg::fill);
  assign fill        = (state == cache_pkg::fill);
  assign sdreq_valid = (state == cache_pkg::send_sdreq);
  assign sursp_ready = (state == cache_pkg::fill);
  assign cursp_valid = (state == cache_pkg::send_rsp);

endmodule

/* hdl/cache_store.sv */
`timescale 1ns/1ps

module cache_store #(
  parameter  int addr_width = 16,
  parameter  int blk_width  = 32,
  parameter  int num_set    = 16,
  localparam int idx_width  = $clog2(num_set)
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    capture,
  input  logic                    commit,
  input  logic                    fill,
  input  cache_pkg::cdreq_op_e    cdreq_op,
  input  logic [addr_width-1:0]   cdreq_addr,
  input  logic [blk_width-1:0]    cdreq_data,
  input  cache_pkg::sursp_e       sursp_rsp,
  input  logic [blk_width-1:0]    sursp_data,
  input  cache_pkg::way_t         victim,
  output cache_pkg::lookup_t      lookup,
  output cache_pkg::cdreq_op_e    req_op,
  output logic [addr_width-1:0]   sdreq_addr,
  output logic [blk_width-1:0]    cursp_data,
  output logic [idx_width-1:0]    set_idx,
  output cache_pkg::way_t         way
);

  localparam int tag_width = addr_width - idx_width;

  typedef logic [addr_width-1:0] addr_t;
  typedef logic [blk_width-1:0]  blk_t;
  typedef logic [tag_width-1:0]  tag_t;

  // ----------------------------------------------------------------------
  // one-slot request buffer
  // ----------------------------------------------------------------------
  cache_pkg::cdreq_op_e buf_op;
  addr_t                buf_addr;
  blk_t                 buf_data;
  tag_t                 buf_tag;

  always_ff @(posedge clk) begin
    if (capture) begin
      buf_op   <= cdreq_op;
      buf_addr <= cdreq_addr;
      buf_data <= cdreq_data;
    end
  end

  assign set_idx    = buf_addr[idx_width-1:0];
  assign buf_tag    = buf_addr[addr_width-1:idx_width];
  assign req_op     = buf_op;
  assign sdreq_addr = buf_addr;

  // ----------------------------------------------------------------------
  // block arrays
  // ----------------------------------------------------------------------
  tag_t              tag_mem  [num_set][cache_pkg::num_way];
  cache_pkg::blk_st_e st_mem  [num_set][cache_pkg::num_way];
  blk_t              data_mem [num_set][cache_pkg::num_way];

  logic              hit;
  logic              has_inv;
  cache_pkg::way_t   hit_way;
  cache_pkg::way_t   inv_way;

  // scan from the top so the lowest invalid way wins
  always_comb begin
    hit     = 1'b0;
    has_inv = 1'b0;
    hit_way = '0;
    inv_way = '0;
    for (int w = cache_pkg::num_way - 1; w >= 0; w--) begin
      if (st_mem[set_idx][w] == cache_pkg::invalid) begin
        has_inv = 1'b1;
        inv_way = cache_pkg::way_t'(w);
      end else if (tag_mem[set_idx][w] == buf_tag) begin
        hit     = 1'b1;
        hit_way = cache_pkg::way_t'(w);
      end
    end
  end

  assign way = hit ? hit_way : (has_inv ? inv_way : victim);

  assign lookup.hit    = hit;
  assign lookup.blk_st = st_mem[set_idx][way];

  // wb returns no data
  assign cursp_data = (buf_op == cache_pkg::cdreq_wb) ? '0 : data_mem[set_idx][way];

  // ----------------------------------------------------------------------
  // commit
  // ----------------------------------------------------------------------
  cache_pkg::blk_st_e st_nxt;
  logic               data_we;
  blk_t               data_nxt;

  always_comb begin
    case (buf_op)
      cache_pkg::cdreq_rd: begin
        if (hit) begin
          st_nxt = lookup.blk_st;
        end else if (sursp_rsp == cache_pkg::sursp_snoop) begin
          st_nxt = cache_pkg::shared;
        end else begin
          st_nxt = cache_pkg::exclusive;
        end
      end
      cache_pkg::cdreq_rfo: st_nxt = cache_pkg::migrated;
      default:              st_nxt = cache_pkg::modified;
    endcase
  end

  // wb data beats fill data and a hit keeps what is stored
  always_comb begin
    data_we  = 1'b0;
    data_nxt = buf_data;
    if (buf_op == cache_pkg::cdreq_wb) begin
      data_we = 1'b1;
    end else if (fill && !hit) begin
      data_we  = 1'b1;
      data_nxt = sursp_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < num_set; s++) begin
        for (int w = 0; w < cache_pkg::num_way; w++) begin
          st_mem[s][w] <= cache_pkg::invalid;
        end
      end
    end else if (commit) begin
      st_mem[set_idx][way] <= st_nxt;
    end
  end

  always_ff @(posedge clk) begin
    if (commit) begin
      tag_mem[set_idx][way] <= buf_tag;
      if (data_we) begin
        data_mem[set_idx][way] <= data_nxt;
      end
    end
  end

endmodule

/* hdl/cache_ctrl.sv */
`timescale 1ns/1ps

module cache_ctrl #(
  parameter int addr_width = 16,
  parameter int blk_width  = 32,
  parameter int num_set    = 16
) (
  input  logic                  clk,
  input  logic                  rst_n,
  // cpu request
  input  logic                  cdreq_valid,
  input  cache_pkg::cdreq_op_e  cdreq_op,
  input  logic [addr_width-1:0] cdreq_addr,
  input  logic [blk_width-1:0]  cdreq_data,
  output logic                  cdreq_ready,
  // cpu response
  output logic                  cursp_valid,
  output logic [blk_width-1:0]  cursp_data,
  input  logic                  cursp_ready,
  // downstream request
  output logic                  sdreq_valid,
  output cache_pkg::sdreq_op_e  sdreq_op,
  output logic [addr_width-1:0] sdreq_addr,
  input  logic                  sdreq_ready,
  // fill response
  input  logic                  sursp_valid,
  input  cache_pkg::sursp_e     sursp_rsp,
  input  logic [blk_width-1:0]  sursp_data,
  output logic                  sursp_ready
);

  localparam int idx_width = $clog2(num_set);

  logic                 capture;
  logic                 commit;
  logic                 fill;
  cache_pkg::lookup_t   lookup;
  cache_pkg::cdreq_op_e req_op;
  logic [idx_width-1:0] set_idx;
  cache_pkg::way_t      way;
  cache_pkg::way_t      victim;

  cache_req_fsm u_fsm (
    .clk         (clk),
    .rst_n       (rst_n),
    .cdreq_valid (cdreq_valid),
    .lookup      (lookup),
    .req_op      (req_op),
    .sdreq_ready (sdreq_ready),
    .sursp_valid (sursp_valid),
    .cursp_ready (cursp_ready),
    .capture     (capture),
    .commit      (commit),
    .fill        (fill),
    .cdreq_ready (cdreq_ready),
    .sdreq_valid (sdreq_valid),
    .sdreq_op    (sdreq_op),
    .sursp_ready (sursp_ready),
    .cursp_valid (cursp_valid)
  );

  cache_store #(
    .addr_width (addr_width),
    .blk_width  (blk_width),
    .num_set    (num_set)
  ) u_store (
    .clk        (clk),
    .rst_n      (rst_n),
    .capture    (capture),
    .commit     (commit),
    .fill       (fill),
    .cdreq_op   (cdreq_op),
    .cdreq_addr (cdreq_addr),
    .cdreq_data (cdreq_data),
    .sursp_rsp  (sursp_rsp),
    .sursp_data (sursp_data),
    .victim     (victim),
    .lookup     (lookup),
    .req_op     (req_op),
    .sdreq_addr (sdreq_addr),
    .cursp_data (cursp_data),
    .set_idx    (set_idx),
    .way        (way)
  );

  // tree is touched on every commit
  plru_repl #(
    .num_set (num_set)
  ) u_repl (
    .clk     (clk),
    .rst_n   (rst_n),
    .set_idx (set_idx),
    .touch   (commit),
    .way     (way),
    .victim  (victim)
  );

endmodule

/* tests/cache_ctrl_assert.sv */
`timescale 1ns/1ps

module cache_ctrl_assert #(
  parameter int addr_width = 16,
  parameter int blk_width  = 32
) (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  cdreq_ready,
  input logic                  cursp_valid,
  input logic                  cursp_ready,
  input logic [blk_width-1:0]  cursp_data,
  input logic                  sdreq_valid,
  input logic                  sdreq_ready,
  input cache_pkg::sdreq_op_e  sdreq_op,
  input logic [addr_width-1:0] sdreq_addr,
  input logic                  sursp_ready
);

  // count of failed checks
  int fail_cnt = 0;

  // ----------------------------------------------------------------------
  // ready pulses
  // ----------------------------------------------------------------------
  cdreq_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    cdreq_ready |=> !cdreq_ready)
    else begin
      fail_cnt++;
      $error("cdreq_ready stayed high for more than one cycle");
    end

  sursp_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    sursp_ready |=> !sursp_ready)
    else begin
      fail_cnt++;
      $error("sursp_ready stayed high for more than one cycle");
    end

  // ----------------------------------------------------------------------
  // valid and payload held until ready
  // ----------------------------------------------------------------------
  cursp_hold: assert property (@(posedge clk) disable iff (!rst_n)
    cursp_valid && !cursp_ready |=> cursp_valid && $stable(cursp_data))
    else begin
      fail_cnt++;
      $error("cursp_valid or cursp_data changed before cursp_ready");
    end

  sdreq_hold: assert property (@(posedge clk) disable iff (!rst_n)
    sdreq_valid && !sdreq_ready |=>
      sdreq_valid && $stable(sdreq_op) && $stable(sdreq_addr))
    else begin
      fail_cnt++;
      $error("sdreq_valid or its payload changed before sdreq_ready");
    end

  // one request in flight
  valid_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(sdreq_valid && cursp_valid))
    else begin
      fail_cnt++;
      $error("sdreq_valid and cursp_valid were high together");
    end

endmodule

bind cache_ctrl cache_ctrl_assert #(
  .addr_width (addr_width),
  .blk_width  (blk_width)
) u_assert (
  .clk         (clk),
  .rst_n       (rst_n),
  .cdreq_ready (cdreq_ready),
  .cursp_valid (cursp_valid),
  .cursp_ready (cursp_ready),
  .cursp_data  (cursp_data),
  .sdreq_valid (sdreq_valid),
  .sdreq_ready (sdreq_ready),
  .sdreq_op    (sdreq_op),
  .sdreq_addr  (sdreq_addr),
  .sursp_ready (sursp_ready)
);

/* tests/cache_ctrl_tb.sv */
`timescale 1ns/1ps

module cache_ctrl_tb;

  localparam int addr_width = 16;
  localparam int blk_width  = 32;
  localparam int num_set    = 16;
  localparam int idx_width  = 4;
  localparam int tag_width  = addr_width - idx_width;
  localparam int timeout    = 100;

  typedef logic [addr_width-1:0] addr_t;
  typedef logic [blk_width-1:0]  blk_t;
  typedef logic [tag_width-1:0]  tag_t;

  logic                 clk;
  logic                 rst_n;
  logic                 cdreq_valid;
  cache_pkg::cdreq_op_e cdreq_op;
  addr_t                cdreq_addr;
  blk_t                 cdreq_data;
  logic                 cdreq_ready;
  logic                 cursp_valid;
  blk_t                 cursp_data;
  logic                 cursp_ready;
  logic                 sdreq_valid;
  cache_pkg::sdreq_op_e sdreq_op;
  addr_t                sdreq_addr;
  logic                 sdreq_ready;
  logic                 sursp_valid;
  cache_pkg::sursp_e    sursp_rsp;
  blk_t                 sursp_data;
  logic                 sursp_ready;

  integer seed;
  int     sdreq_cnt;
  int     cnt0;
  addr_t  evicted;
  addr_t  lost;

  // reference model of the block store and the tree bits
  tag_t               m_tag  [num_set][cache_pkg::num_way];
  cache_pkg::blk_st_e m_st   [num_set][cache_pkg::num_way];
  blk_t               m_data [num_set][cache_pkg::num_way];
  logic [2:0]         m_tree [num_set];

  cache_ctrl #(
    .addr_width (addr_width),
    .blk_width  (blk_width),
    .num_set    (num_set)
  ) uut (.*);

  always #50 clk = ~clk;

  // completed downstream transfers
  always @(posedge clk) begin
    if (sdreq_valid && sdreq_ready) begin
      sdreq_cnt <= sdreq_cnt + 1;
    end
  end

  always @(negedge clk) begin
    if (uut.u_assert.fail_cnt != 0) begin
      abort_run("a protocol assertion on cache_ctrl failed");
    end
  end

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (exp == act) else begin
      $display("MISMATCH %s: expected %0h, actual %0h", name, exp, act);
      $display("test failed");
      $fatal(1);
    end
  endtask

  // ----------------------------------------------------------------------
  // tree pseudo-LRU of the model
  // ----------------------------------------------------------------------
  function automatic cache_pkg::way_t victim_of(input logic [2:0] t);
    if (t[2]) begin
      return t[0] ? 2'd3 : 2'd2;
    end
    return t[1] ? 2'd1 : 2'd0;
  endfunction

  function automatic logic [2:0] touched_tree(input logic [2:0] t, input cache_pkg::way_t w);
    logic [2:0] r;
    r = t;
    case (w)
      2'd0: r[2:1] = 2'b11;
      2'd1: r[2:1] = 2'b10;
      2'd2: begin
        r[2] = 1'b0;
        r[0] = 1'b1;
      end
      default: begin
        r[2] = 1'b0;
        r[0] = 1'b0;
      end
    endcase
    return r;
  endfunction

  // ----------------------------------------------------------------------
  // next level, accepts a downstream request and returns the fill
  // ----------------------------------------------------------------------
  task automatic answer_downstream(input string name, input cache_pkg::sursp_e rsp,
                                   input blk_t data);
    int n;
    repeat ({$random(seed)} % 4) @(negedge clk);
    sdreq_ready = 1'b1;
    @(negedge clk);
    sdreq_ready = 1'b0;
    sursp_valid = 1'b1;
    sursp_rsp   = rsp;
    sursp_data  = data;
    n = 0;
    while (!sursp_ready) begin
      @(negedge clk);
      n++;
      if (n > timeout) begin
        abort_run({name, ": sursp_ready did not rise"});
      end
    end
    sursp_valid = 1'b0;
  endtask

  // ----------------------------------------------------------------------
  // one cpu request with downstream responder and model update
  // ----------------------------------------------------------------------
  task automatic run_request(input string name, input cache_pkg::cdreq_op_e op,
                             input addr_t addr, input blk_t data,
                             input cache_pkg::sursp_e rsp);
    logic [idx_width-1:0] set;
    tag_t                 tag;
    cache_pkg::way_t      w;
    logic                 hit;
    logic                 has_inv;
    logic                 down;
    cache_pkg::sdreq_op_e exp_op;
    blk_t                 fill_data;
    blk_t                 exp_data;
    int                   start_cnt;
    int                   n;
    set       = addr[idx_width-1:0];
    tag       = addr[addr_width-1:idx_width];
    hit       = 1'b0;
    has_inv   = 1'b0;
    w         = victim_of(m_tree[set]);
    fill_data = $random(seed);
    for (int i = 0; i < cache_pkg::num_way; i++) begin
      if (!has_inv && m_st[set][i] == cache_pkg::invalid) begin
        has_inv = 1'b1;
        w       = cache_pkg::way_t'(i);
      end
    end
    for (int i = 0; i < cache_pkg::num_way; i++) begin
      if (m_st[set][i] != cache_pkg::invalid && m_tag[set][i] == tag) begin
        hit = 1'b1;
        w   = cache_pkg::way_t'(i);
      end
    end
    down   = !hit || (op != cache_pkg::cdreq_rd && m_st[set][w] == cache_pkg::shared);
    exp_op = cache_pkg::sdreq_inv;
    if (!hit) begin
      exp_op = (op == cache_pkg::cdreq_rd) ? cache_pkg::sdreq_rd : cache_pkg::sdreq_rfo;
    end
    if (!hit && !has_inv) begin
      evicted = {m_tag[set][w], set};
    end

    start_cnt   = sdreq_cnt;
    cdreq_valid = 1'b1;
    cdreq_op    = op;
    cdreq_addr  = addr;
    cdreq_data  = data;
    n = 0;
    while (!cdreq_ready) begin
      @(negedge clk);
      n++;
      if (n > timeout) begin
        abort_run({name, ": cdreq_ready did not rise"});
      end
    end
    cdreq_valid = 1'b0;
    check_value({name, " accept cycles"}, 1, n);

    // the dut decides on its own whether it goes downstream
    n = 0;
    while (!sdreq_valid && !cursp_valid) begin
      @(negedge clk);
      n++;
      if (n > timeout) begin
        abort_run({name, ": neither sdreq_valid nor cursp_valid rose"});
      end
    end
    if (!down) begin
      check_value({name, " response latency"}, 1, n);
    end
    if (sdreq_valid) begin
      check_value({name, " sdreq_op"}, exp_op, sdreq_op);
      check_value({name, " sdreq_addr"}, addr, sdreq_addr);
      answer_downstream(name, rsp, fill_data);
      n = 0;
      while (!cursp_valid) begin
        @(negedge clk);
        n++;
        if (n > timeout) begin
          abort_run({name, ": cursp_valid did not rise"});
        end
      end
    end

    // expected block after commit
    case (op)
      cache_pkg::cdreq_rd: begin
        if (!hit) begin
          m_st[set][w]   = cache_pkg::exclusive;
          m_data[set][w] = fill_data;
          if (rsp == cache_pkg::sursp_snoop) begin
            m_st[set][w] = cache_pkg::shared;
          end
        end
      end
      cache_pkg::cdreq_rfo: begin
        m_st[set][w] = cache_pkg::migrated;
        if (!hit) begin
          m_data[set][w] = fill_data;
        end
      end
      default: begin
        m_st[set][w]   = cache_pkg::modified;
        m_data[set][w] = data;
      end
    endcase
    m_tag[set][w] = tag;
    m_tree[set]   = touched_tree(m_tree[set], w);
    exp_data      = (op == cache_pkg::cdreq_wb) ? '0 : m_data[set][w];

    repeat ({$random(seed)} % 4) @(negedge clk);
    check_value({name, " cursp_valid held"}, 1, cursp_valid);
    check_value({name, " cursp_data"}, exp_data, cursp_data);
    cursp_ready = 1'b1;
    @(negedge clk);
    cursp_ready = 1'b0;
    check_value({name, " downstream requests"}, down, sdreq_cnt - start_cnt);
  endtask

  initial begin
    seed        = 32'hc4eb;
    sdreq_cnt   = 0;
    clk         = 1'b0;
    rst_n       = 1'b0;
    cdreq_valid = 1'b0;
    cdreq_op    = cache_pkg::cdreq_rd;
    cdreq_addr  = '0;
    cdreq_data  = '0;
    cursp_ready = 1'b0;
    sdreq_ready = 1'b0;
    sursp_valid = 1'b0;
    sursp_rsp   = cache_pkg::sursp_snoop;
    sursp_data  = '0;
    evicted     = '0;
    for (int s = 0; s < num_set; s++) begin
      m_tree[s] = 3'b000;
      for (int w = 0; w < cache_pkg::num_way; w++) begin
        m_st[s][w]   = cache_pkg::invalid;
        m_tag[s][w]  = '0;
        m_data[s][w] = '0;
      end
    end
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    check_value("reset outputs", 0, {cdreq_ready, cursp_valid, sdreq_valid, sursp_ready});

    // read miss followed by a hit
    run_request("rd_miss", cache_pkg::cdreq_rd, 16'h0011, '0, cache_pkg::sursp_fetch);
    run_request("rd_hit", cache_pkg::cdreq_rd, 16'h0011, '0, cache_pkg::sursp_fetch);
    // rfo on shared and on exclusive copies
    run_request("rd_snoop", cache_pkg::cdreq_rd, 16'h0022, '0, cache_pkg::sursp_snoop);
    run_request("rfo_shared", cache_pkg::cdreq_rfo, 16'h0022, '0, cache_pkg::sursp_snoop);
    run_request("rfo_excl", cache_pkg::cdreq_rfo, 16'h0011, '0, cache_pkg::sursp_fetch);
    // write-back hit and miss
    run_request("wb_hit", cache_pkg::cdreq_wb, 16'h0011, 32'h1234_abcd, cache_pkg::sursp_fetch);
    run_request("rd_after_wb", cache_pkg::cdreq_rd, 16'h0011, '0, cache_pkg::sursp_fetch);
    run_request("wb_miss", cache_pkg::cdreq_wb, 16'h0033, 32'h5a5a_0f0f, cache_pkg::sursp_fetch);
    run_request("rd_after_wb_miss", cache_pkg::cdreq_rd, 16'h0033, '0, cache_pkg::sursp_fetch);
    run_request("rfo_miss", cache_pkg::cdreq_rfo, 16'h0044, '0, cache_pkg::sursp_snoop);

    // ----------------------------------------------------------------------
    // replacement in set 5
    // ----------------------------------------------------------------------
    for (int t = 1; t <= 4; t++) begin
      run_request("fill_set", cache_pkg::cdreq_rd, addr_t'(t * 16 + 5), '0,
                  cache_pkg::sursp_fetch);
    end
    run_request("reuse_1", cache_pkg::cdreq_rd, 16'h0015, '0, cache_pkg::sursp_fetch);
    run_request("reuse_3", cache_pkg::cdreq_rd, 16'h0035, '0, cache_pkg::sursp_fetch);
    run_request("evict", cache_pkg::cdreq_rd, 16'h0055, '0, cache_pkg::sursp_fetch);
    lost = evicted;
    cnt0 = sdreq_cnt;
    for (int t = 1; t <= 5; t++) begin
      if (addr_t'(t * 16 + 5) != lost) begin
        run_request("kept_tag", cache_pkg::cdreq_rd, addr_t'(t * 16 + 5), '0,
                    cache_pkg::sursp_fetch);
      end
    end
    check_value("kept tags hit", 0, sdreq_cnt - cnt0);
    run_request("evicted_tag", cache_pkg::cdreq_rd, lost, '0, cache_pkg::sursp_fetch);
    check_value("evicted tag missed", 1, sdreq_cnt - cnt0);

    if (uut.u_assert.fail_cnt == 0) begin
      $display("test passed");
      $finish;
    end else begin
      $display("test failed");
      $fatal(1);
    end
  end

endmodule

/* cache_ctrl.f */
hdl/cache_pkg.sv
hdl/plru_repl.sv
hdl/cache_req_fsm.sv
hdl/cache_store.sv
hdl/cache_ctrl.sv
tests/cache_ctrl_assert.sv
tests/cache_ctrl_tb.sv

/* Bender.yml */
package:
  name: cache_ctrl

sources:
  - files:
      - hdl/cache_pkg.sv
      - hdl/plru_repl.sv
      - hdl/cache_req_fsm.sv
      - hdl/cache_store.sv
      - hdl/cache_ctrl.sv
  - target: test
    files:
      - tests/cache_ctrl_assert.sv
      - tests/cache_ctrl_tb.sv
